/* src.f */
design/cpu_pkg.sv
design/stage_sequencer.sv
design/retire_counter.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/main_memory.sv
design/cpu_multicycle.sv
tb/tb_cpu.sv

/* Makefile */
sim:
	verilator --binary --timing -Wno-fatal -f src.f --top-module tb_cpu -o vtb_cpu
	out=$$(./obj_dir/vtb_cpu); echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

.PHONY: sim clean

/* tb/cpu_stim.txt */
# P addr count words | G addr rd store_addr | R run | E addr word | C retired | T end of test
# All numbers are hex
P 00 06 10800123 1100FF85 11800080 12000081 300C2000 30104000
G 06 05 82
P 07 03 13000082 3018A000 60000000
R
E 80 00000123
E 81 FFFFFF85
C 0000000A
T
# ALU: r1 = -8, r2 = 3, results stored from 0x90 upwards
P 00 04 1080FFF8 11000003 11800090 12000001
P 04 06 42844000 300CA000 418C8000 42844400 300CA000 418C8000
P 0A 06 42844800 300CA000 418C8000 42844C00 300CA000 418C8000
P 10 06 42845000 300CA000 418C8000 42845400 300CA000 418C8000
P 16 07 42845800 300CA000 418C8000 42845C00 300CA000 418C8000 60000000
R
E 90 FFFFFFFB
E 91 FFFFFFF5
E 92 00000000
E 93 FFFFFFFB
E 94 FFFFFFFB
E 95 FFFFFFC0
E 96 1FFFFFFF
E 97 00000001
C 0000001D
T
# Copy 0xA0..0xA1 to 0xB0..0xB1
P A0 02 DEADBEEF 12345678
P 00 0A 108000A0 110000B0 21840000 30086000 12000001 40848000 41088000 21840000 30086000 60000000
R
E B0 DEADBEEF
E B1 12345678
C 0000000A
T
# Countdown loop from 5, sum stored at 0xC0
P 00 0A 10800005 11000000 1180FFFF 12000004 41082000 40846000 50048000 128000C0 30144000 60000000
R
E C0 0000000F
C 00000016
T
# Write to r0 is dropped
P 00 05 10800007 40042000 110000D0 30080000 60000000
R
E D0 00000000
C 00000005
T
# Second program, earlier results persist
P 00 04 10800055 11000081 30082000 60000000
R
E 81 00000055
E 80 00000123
E C0 0000000F
C 00000004
T

/* tb/tb_cpu.sv */
`timescale 1ns/1ps

module tb_cpu;
   import cpu_pkg::*;

   logic                  clk;
   logic                  rst;
   logic                  prog_we;
   logic [MEM_ADDR_W-1:0] prog_addr;
   logic [XLEN-1:0]       prog_data;
   logic                  run;
   logic [MEM_ADDR_W-1:0] dbg_addr;
   logic [XLEN-1:0]       dbg_data;
   logic                  halted;
   logic [15:0]           retired;

   int                    test_errors;
   int                    total_errors;
   bit                    timed_out;
   integer                seed;

   // Expected words from generated immediates that are checked at end of test
   logic [MEM_ADDR_W-1:0] gen_addr_q [$];
   logic [XLEN-1:0]       gen_val_q [$];

   cpu_multicycle DUT (
      .clk       (clk),
      .rst       (rst),
      .prog_we   (prog_we),
      .prog_addr (prog_addr),
      .prog_data (prog_data),
      .run       (run),
      .dbg_addr  (dbg_addr),
      .dbg_data  (dbg_data),
      .halted    (halted),
      .retired   (retired)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("FAIL %s: got %08h expected %08h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic load_word(input logic [MEM_ADDR_W-1:0] addr, input logic [XLEN-1:0] word);
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= addr;
      prog_data <= word;
   endtask

   task automatic end_load();
      @(posedge clk);
      prog_we <= 1'b0;
   endtask

   task automatic run_program();
      int cycles;
      cycles = 0;
      @(posedge clk);
      run <= 1'b1;
      @(negedge clk);
      while (halted && cycles < 20) begin
         @(negedge clk);
         cycles++;
      end
      if (halted) begin
         $display("Timeout: the core did not leave the halted state within 20 cycles");
         timed_out = 1'b1;
      end
      cycles = 0;
      while (!halted && cycles < 2000) begin
         @(negedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("Timeout: the core did not halt within 2000 cycles");
         timed_out = 1'b1;
      end
      @(posedge clk);
      run <= 1'b0;
      // Halt state returns to idle one clock after run drops
      repeat (2) @(posedge clk);
   endtask

   task automatic read_word(input logic [MEM_ADDR_W-1:0] addr, output logic [XLEN-1:0] word);
      @(posedge clk);
      dbg_addr <= addr;
      @(negedge clk);
      word = dbg_data;
   endtask

   initial begin
      integer                fd;
      integer                code;
      integer                count;
      int                    test_num;
      int                    failed_tests;
      logic [63:0]           tag;
      logic [8*200-1:0]      line;
      logic [MEM_ADDR_W-1:0] addr;
      logic [31:0]           word;
      logic [31:0]           got;
      logic [4:0]            rd;
      logic [15:0]           imm;

      seed         = 32'hc447ec81;
      rst          = 1'b0;
      prog_we      = 1'b0;
      prog_addr    = '0;
      prog_data    = '0;
      run          = 1'b0;
      dbg_addr     = '0;
      test_errors  = 0;
      total_errors = 0;
      timed_out    = 1'b0;
      test_num     = 0;
      failed_tests = 0;

      repeat (4) @(posedge clk);
      rst <= 1'b1;
      @(posedge clk);

      fd = $fopen("tb/cpu_stim.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file tb/cpu_stim.txt");
         total_errors++;
      end else begin
         while (!$feof(fd) && !timed_out) begin
            tag  = '0;
            code = $fscanf(fd, "%s", tag);
            if (code != 1) begin
               tag = "#";
            end
            if (tag == "#") begin
               code = $fgets(line, fd);
            end else if (tag == "P") begin
               code = $fscanf(fd, "%h %h", addr, count);
               for (int i = 0; i < count; i++) begin
                  code = $fscanf(fd, "%h", word);
                  load_word(addr + i[MEM_ADDR_W-1:0], word);
               end
               end_load();
            end else if (tag == "G") begin
               // Random LOADI immediate whose stored value is checked at end of test
               code = $fscanf(fd, "%h %h %h", addr, rd, word);
               imm  = $random(seed);
               load_word(addr, {4'h1, rd, 7'b0, imm});
               end_load();
               gen_addr_q.push_back(word[MEM_ADDR_W-1:0]);
               gen_val_q.push_back({{16{imm[15]}}, imm});
            end else if (tag == "R") begin
               run_program();
            end else if (tag == "E") begin
               code = $fscanf(fd, "%h %h", addr, word);
               read_word(addr, got);
               check_value("dbg_data", got, word);
            end else if (tag == "C") begin
               code = $fscanf(fd, "%h", word);
               @(negedge clk);
               check_value("retired", {16'h0, retired}, word);
            end else if (tag == "T") begin
               while (gen_addr_q.size() > 0) begin
                  read_word(gen_addr_q.pop_front(), got);
                  check_value("dbg_data", got, gen_val_q.pop_front());
               end
               test_num++;
               if (test_errors == 0) begin
                  $display("Test %0d passed", test_num);
               end else begin
                  $display("Test %0d failed with %0d mismatches", test_num, test_errors);
                  failed_tests++;
               end
               total_errors += test_errors;
               test_errors = 0;
            end else begin
               $display("Unknown tag in the stimulus file: %0s", tag);
               total_errors++;
            end
         end
         $fclose(fd);
      end

      total_errors += test_errors;
      $display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
               test_num, failed_tests, total_errors);
      if (total_errors == 0 && !timed_out && test_num > 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* design/cpu_multicycle.sv */
`timescale 1ns/1ps

module cpu_multicycle (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             prog_we,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0]   prog_addr,
   input  logic [cpu_pkg::XLEN-1:0]         prog_data,
   input  logic                             run,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0]   dbg_addr,
   output logic [cpu_pkg::XLEN-1:0]         dbg_data,
   output logic                             halted,
   output logic [15:0]                      retired
);
   import cpu_pkg::*;

   stage_ctrl_t           ctrl;
   decoded_t              dec;
   logic [MEM_ADDR_W-1:0] pc;
   logic [XLEN-1:0]       instr;
   logic [XLEN-1:0]       rf_a, rf_b;
   logic [XLEN-1:0]       operand_a, operand_b;
   logic [XLEN-1:0]       alu_result;
   logic [XLEN-1:0]       mem_rdata, mem_result;
   logic [XLEN-1:0]       wb_data;
   logic                  mem_we;
   logic [MEM_ADDR_W-1:0] mem_waddr, mem_raddr;
   logic [XLEN-1:0]       mem_wdata;
   logic                  halted_q;
   logic                  run_start;

   stage_sequencer u_seq (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .dec       (dec),
      .operand_a (operand_a),
      .operand_b (operand_b),
      .mem_rdata (mem_rdata),
      .ctrl      (ctrl),
      .pc        (pc),
      .instr     (instr),
      .halted    (halted)
   );

   instr_decoder u_dec (
      .instr (instr),
      .dec   (dec)
   );

   register_file u_rf (
      .clk     (clk),
      .rst     (rst),
      .we      (ctrl.wb_en),
      .waddr   (dec.rd),
      .wdata   (wb_data),
      .raddr_a (dec.ra),
      .raddr_b (dec.rb),
      .rdata_a (rf_a),
      .rdata_b (rf_b)
   );

   // Decode stage operand registers and memory stage result
   always_ff @(posedge clk) begin
      if (ctrl.operand_load) begin
         operand_a <= rf_a;
         operand_b <= rf_b;
      end
      if (ctrl.mem_access)
         mem_result <= mem_rdata;
   end

   alu u_alu (
      .clk    (clk),
      .rst    (rst),
      .load   (ctrl.alu_load),
      .op     (dec.alu_op),
      .in_a   (operand_a),
      .in_b   (operand_b),
      .result (alu_result)
   );

   // Loader owns the write port while the core is stopped
   assign mem_we    = halted ? prog_we : (ctrl.mem_access && dec.opcode == OP_STORE);
   assign mem_waddr = halted ? prog_addr : operand_a[MEM_ADDR_W-1:0];
   assign mem_wdata = halted ? prog_data : operand_b;
   assign mem_raddr = ctrl.mem_access ? operand_a[MEM_ADDR_W-1:0] : pc;

   main_memory u_mem (
      .clk       (clk),
      .we        (mem_we),
      .waddr     (mem_waddr),
      .wdata     (mem_wdata),
      .raddr     (mem_raddr),
      .dbg_addr  (dbg_addr),
      .rdata     (mem_rdata),
      .dbg_rdata (dbg_data)
   );

   always_comb begin
      case (dec.opcode)
         OP_LOADI: wb_data = dec.imm;
         OP_LOAD:  wb_data = mem_result;
         default:  wb_data = alu_result;
      endcase
   end

   // Falling edge of halted marks the start of a run
   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         halted_q <= 1'b1;
      else
         halted_q <= halted;
   end

   assign run_start = halted_q && !halted;

   retire_counter u_cnt (
      .clk    (clk),
      .rst    (rst),
      .clear  (run_start),
      .retire (ctrl.retire),
      .count  (retired)
   );

endmodule

/* design/main_memory.sv */
`timescale 1ns/1ps

module main_memory (
   input  logic                             clk,
   input  logic                             we,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0]   waddr,
   input  logic [cpu_pkg::XLEN-1:0]         wdata,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0]   raddr,
   input  logic [cpu_pkg::MEM_ADDR_W-1:0]   dbg_addr,
   output logic [cpu_pkg::XLEN-1:0]         rdata,
   output logic [cpu_pkg::XLEN-1:0]         dbg_rdata
);
   import cpu_pkg::*;

   // Shared instruction and data storage
   logic [XLEN-1:0] mem [MEM_DEPTH];

   always_ff @(posedge clk) begin
      if (we)
         mem[waddr] <= wdata;
   end

   // Core port
   assign rdata = mem[raddr];

   // Debug port for the outside world
   assign dbg_rdata = mem[dbg_addr];

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
   input  logic                     clk,
   input  logic                     rst,
   input  logic                     load,
   input  cpu_pkg::alu_op_e         op,
   input  logic [cpu_pkg::XLEN-1:0] in_a,
   input  logic [cpu_pkg::XLEN-1:0] in_b,
   output logic [cpu_pkg::XLEN-1:0] result
);
   import cpu_pkg::*;

   logic [XLEN-1:0] next_result;
   logic [4:0]      shamt;

   assign shamt = in_b[4:0];

   always_comb begin
      case (op)
         ALU_ADD: next_result = in_a + in_b;
         ALU_SUB: next_result = in_a - in_b;
         ALU_AND: next_result = in_a & in_b;
         ALU_OR:  next_result = in_a | in_b;
         ALU_XOR: next_result = in_a ^ in_b;
         ALU_SHL: next_result = in_a << shamt;
         ALU_SHR: next_result = in_a >> shamt;
         // Signed compare giving 0 or 1
         ALU_SLT: next_result = {{(XLEN-1){1'b0}}, $signed(in_a) < $signed(in_b)};
         default: next_result = '0;
      endcase
   end

   // Execute stage result register
   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         result <= '0;
      else if (load)
         result <= next_result;
   end

endmodule

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             we,
   input  logic [cpu_pkg::REG_ADDR_W-1:0]   waddr,
   input  logic [cpu_pkg::XLEN-1:0]         wdata,
   input  logic [cpu_pkg::REG_ADDR_W-1:0]   raddr_a,
   input  logic [cpu_pkg::REG_ADDR_W-1:0]   raddr_b,
   output logic [cpu_pkg::XLEN-1:0]         rdata_a,
   output logic [cpu_pkg::XLEN-1:0]         rdata_b
);
   import cpu_pkg::*;

   logic [XLEN-1:0] regs [2**REG_ADDR_W];

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         for (int i = 0; i < 2**REG_ADDR_W; i++)
            regs[i] <= '0;
      end else if (we && waddr != '0) begin
         regs[waddr] <= wdata;
      end
   end

   // Register 0 is never written and reads as zero
   assign rdata_a = regs[raddr_a];
   assign rdata_b = regs[raddr_b];

endmodule

/* design/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder (
   input  logic [cpu_pkg::XLEN-1:0] instr,
   output cpu_pkg::decoded_t        dec
);
   import cpu_pkg::*;

   opcode_e raw_op;

   assign raw_op = opcode_e'(instr[31:28]);

   always_comb begin
      dec.alu_op = alu_op_e'(instr[12:10]);
      dec.rd     = instr[27:23];
      dec.ra     = instr[22:18];
      dec.rb     = instr[17:13];
      // Immediate shares bits with rb and the ALU field
      dec.imm    = {{(XLEN-16){instr[15]}}, instr[15:0]};

      case (raw_op)
         OP_LOADI, OP_LOAD, OP_STORE, OP_ALU, OP_JNZ, OP_HALT: begin
            dec.opcode = raw_op;
         end
         default: begin
            // Unknown codes become a no-op aimed at register 0
            dec.opcode = OP_NOP;
            dec.rd     = '0;
         end
      endcase
   end

endmodule

/* design/retire_counter.sv */
`timescale 1ns/1ps

module retire_counter (
   input  logic        clk,
   input  logic        rst,
   input  logic        clear,
   input  logic        retire,
   output logic [15:0] count
);
   import cpu_pkg::*;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (retire && count != 16'hffff) begin
         // Saturate rather than wrap
         count <= count + 1'b1;
      end
   end

endmodule

/* design/stage_sequencer.sv */
`timescale 1ns/1ps

module stage_sequencer (
   input  logic                             clk,
   input  logic                             rst,
   input  logic                             run,
   input  cpu_pkg::decoded_t                dec,
   input  logic [cpu_pkg::XLEN-1:0]         operand_a,
   input  logic [cpu_pkg::XLEN-1:0]         operand_b,
   input  logic [cpu_pkg::XLEN-1:0]         mem_rdata,
   output cpu_pkg::stage_ctrl_t             ctrl,
   output logic [cpu_pkg::MEM_ADDR_W-1:0]   pc,
   output logic [cpu_pkg::XLEN-1:0]         instr,
   output logic                             halted
);
   import cpu_pkg::*;

   stage_e state;

   always_ff @(posedge clk or negedge rst) begin
      if (!rst) begin
         state <= ST_IDLE;
         pc    <= '0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (run) begin
                  state <= ST_FETCH;
                  pc    <= '0;
               end
            end
            ST_FETCH: state <= ST_DECODE;
            ST_DECODE: begin
               pc    <= pc + 1'b1;
               state <= ST_EXEC;
            end
            ST_EXEC: state <= ST_MEM;
            ST_MEM: begin
               // Taken branch overrides the increment from decode
               if (dec.opcode == OP_JNZ && operand_a != '0)
                  pc <= operand_b[MEM_ADDR_W-1:0];
               state <= ST_WB;
            end
            ST_WB: state <= (dec.opcode == OP_HALT) ? ST_HALT : ST_FETCH;
            ST_HALT: begin
               // Wait for run to be released before rearming
               if (!run)
                  state <= ST_IDLE;
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Instruction register
   always_ff @(posedge clk or negedge rst) begin
      if (!rst)
         instr <= '0;
      else if (ctrl.ir_load)
         instr <= mem_rdata;
   end

   always_comb begin
      ctrl = '0;
      case (state)
         ST_FETCH:  ctrl.ir_load      = 1'b1;
         ST_DECODE: ctrl.operand_load = 1'b1;
         ST_EXEC:   ctrl.alu_load     = 1'b1;
         ST_MEM:    ctrl.mem_access   = (dec.opcode == OP_LOAD) || (dec.opcode == OP_STORE);
         ST_WB: begin
            ctrl.wb_en  = (dec.opcode == OP_LOADI) || (dec.opcode == OP_ALU) ||
                          (dec.opcode == OP_LOAD);
            ctrl.retire = 1'b1;
         end
         default: ;
      endcase
   end

   assign halted = (state == ST_IDLE) || (state == ST_HALT);

endmodule

/* design/cpu_pkg.sv */
package cpu_pkg;

   localparam int XLEN       = 32;
   localparam int MEM_ADDR_W = 8;
   localparam int MEM_DEPTH  = 256;
   localparam int REG_ADDR_W = 5;

   // Any code not listed here decodes to OP_NOP
   typedef enum logic [3:0] {
      OP_NOP   = 4'h0,
      OP_LOADI = 4'h1,
      OP_LOAD  = 4'h2,
      OP_STORE = 4'h3,
      OP_ALU   = 4'h4,
      OP_JNZ   = 4'h5,
      OP_HALT  = 4'h6
   } opcode_e;

   typedef enum logic [2:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
      ALU_XOR, ALU_SHL, ALU_SHR, ALU_SLT
   } alu_op_e;

   typedef enum logic [2:0] {
      ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC, ST_MEM, ST_WB, ST_HALT
   } stage_e;

   typedef struct packed {
      opcode_e               opcode;
      alu_op_e               alu_op;
      logic [REG_ADDR_W-1:0] rd;
      logic [REG_ADDR_W-1:0] ra;
      logic [REG_ADDR_W-1:0] rb;
      logic [XLEN-1:0]       imm;
   } decoded_t;

   // One enable per stage action
   typedef struct packed {
      logic ir_load;
      logic operand_load;
      logic alu_load;
      logic mem_access;
      logic wb_en;
      logic retire;
   } stage_ctrl_t;

endpackage
